// File: Makefile
# Verilator build and run for the FM demodulator testbench

VERILATOR ?= verilator
TOP       ?= fm_demod_tb
FILELIST  ?= fm_demod.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/fm_demod_defs.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/fm_demod_checker.sv
`timescale 1ns/1ns
`include "fm_demod_defs.svh"

module fm_demod_checker
    import fm_demod_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    input  angle_t     exp_angle_i,
    input  angle_t     exp_freq_i,
    input  demod_out_t result_i,
    output int         error_count_o,
    output int         pending_o
);

    // table quantisation allowance in angle LSBs
    localparam int TOL       = 2;
    // axes and diagonals need no table rounding
    localparam int EXACT_TOL = 1;

    typedef struct packed {
        angle_t angle;
        angle_t freq;
        int     stamp;
    } expect_t;

    expect_t expect_q[$];
    int      cycle;
    int      errors;
    int      pending;

    assign error_count_o = errors;
    assign pending_o     = pending;

    // difference taken modulo one turn
    task automatic compare_angle(input string name, input angle_t expected,
                                 input angle_t actual, input int tol);
        int diff;
        diff = int'(angle_t'(actual - expected));
        if (diff > tol || diff < -tol) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic record_input();
        expect_t e;
        e.angle = exp_angle_i;
        e.freq  = exp_freq_i;
        e.stamp = cycle;
        expect_q.push_back(e);
    endtask

    task automatic check_output();
        expect_t e;
        int      latency;
        int      angle_tol;
        if (expect_q.size() == 0) begin
            $display("unexpected output at %0t: result_o.valid high with no sample pending",
                     $time);
            errors++;
            return;
        end
        e       = expect_q.pop_front();
        latency = cycle - e.stamp;
        if (latency != `DEMOD_LATENCY) begin
            $display("Error at %0t: result_o latency expected %0d got %0d cycles",
                     $time, `DEMOD_LATENCY, latency);
            errors++;
        end
        // multiples of pi/4 are exact angles
        if (e.angle[`ANGLE_W-4:0] == '0) begin
            angle_tol = EXACT_TOL;
        end else begin
            angle_tol = TOL;
        end
        compare_angle("result_o.angle", e.angle, result_i.angle, angle_tol);
        compare_angle("result_o.freq", e.freq, result_i.freq, TOL);
    endtask

    // inputs and outputs are both taken before the edge updates them
    always @(posedge clk_i) begin
        if (!reset_ni) begin
            cycle = 0;
        end else begin
            cycle++;
            if (sample_i.valid) begin
                record_input();
            end
            if (result_i.valid) begin
                check_output();
            end
        end
        pending = expect_q.size();
    end

endmodule

// File: dv/fm_demod_input.txt
// valid  I  Q  expected_angle  expected_freq (decimal, angles in binary units of 65536 per turn)
// freq is the wrapped difference to the previous valid angle, lines with valid 0 are ignored
1   1000      0       0       0
1      0   1000   16384   16384
1  -1000      0  -32768   16384
1      0  -1000  -16384   16384
1   1000   1000    8192   24576
1      0      0       0   -8192
1  -1000  -1000  -24576  -24576
1   2048   1024    4836   29412
1  -2048   1024   27932   23096
1  -2048  -1024  -27932    9672
1   2048  -1024   -4836   23096
1   1024   2048   11548   16384
1  -1024   2048   21220    9672
1  -1024  -2048  -21220   23096
1   1024  -2048  -11548    9672
1   4000   3000    6712   18260
1  -3000   4000   23096   16384
1  -4000  -1000  -30213   12227
1   1000  -4000  -13829   16384
1   1000      0       0   13829
1   4000   1000    2555    2555
1   2000   1000    4836    2281
1   4000   3000    6712    1876
1   1000   1000    8192    1480
1   3000   4000    9672    1480
1   1000   2000   11548    1876
1   1000   4000   13829    2281
1      0   1000   16384    2555
1  -2000   1000   27932   11548
1  -4000   1000   30213    2281
1  -1000      0  -32768    2555
1  -4000  -1000  -30213    2555
1  -2000  -1000  -27932    2281
1  -4000  -1000  -30213   -2281
1  -1000      0  -32768   -2555
1  -4000   1000   30213   -2555
1  -2000   1000   27932   -2281
0    500   -700       0       0
0   -123    456       0       0
1  -4000   3000   26056   -1876
0      0      0       0       0
1  -3000   4000   23096   -2960
0    999    999       0       0
0   -999   -999       0       0
0      1      1       0       0
1  -1000   2000   21220   -1876
1  -1000   1000   24576    3356
0     10     20       0       0
1  -1000   4000   18939   -5637
1      0   1000   16384   -2555

// File: dv/fm_demod_tb.sv
`timescale 1ns/1ns
`include "fm_demod_defs.svh"

module fm_demod_tb
    import fm_demod_pkg::*;
();

    localparam string INPUT_FILE   = "dv/fm_demod_input.txt";
    localparam int    CLK_HALF     = 2;
    localparam int    RESET_CYCLES = 10;
    localparam int    SLACK_CYCLES = 50;
    localparam int    DRAIN_CYCLES = 3;

    // one line of the data file
    typedef struct packed {
        logic                        valid;
        logic signed [`SAMPLE_W-1:0] i;
        logic signed [`SAMPLE_W-1:0] q;
        angle_t                      angle;
        angle_t                      freq;
    } vector_t;

    logic       clk_i;
    logic       reset_ni;
    iq_sample_t sample;
    demod_out_t result;
    angle_t     exp_angle;
    angle_t     exp_freq;
    int         check_errors;
    int         pending;
    int         tb_errors;
    int         cycles;
    int         timeout_limit;
    vector_t    vectors[$];

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    fm_demod_top UUT (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .sample_i(sample),
        .result_o(result)
    );

    fm_demod_checker u_checker (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .sample_i     (sample),
        .exp_angle_i  (exp_angle),
        .exp_freq_i   (exp_freq),
        .result_i     (result),
        .error_count_o(check_errors),
        .pending_o    (pending)
    );

    // lines that do not hold five numbers are comments
    task automatic load_vectors();
        int               fd;
        int               n;
        int               v_f;
        int               i_f;
        int               q_f;
        int               a_f;
        int               f_f;
        logic [8*256-1:0] line;
        vector_t          v;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", INPUT_FILE);
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %d %d %d", v_f, i_f, q_f, a_f, f_f);
                if (n == 5) begin
                    v.valid = v_f[0];
                    v.i     = i_f[`SAMPLE_W-1:0];
                    v.q     = q_f[`SAMPLE_W-1:0];
                    v.angle = a_f[`ANGLE_W-1:0];
                    v.freq  = f_f[`ANGLE_W-1:0];
                    vectors.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input vector_t v);
        sample.valid = v.valid;
        sample.i     = v.i;
        sample.q     = v.q;
        exp_angle    = v.angle;
        exp_freq     = v.freq;
    endtask

    task automatic print_summary();
        $display("error count %0d (output checks %0d, testbench %0d)",
                 check_errors + tb_errors, check_errors, tb_errors);
    endtask

    // cycle budget counted from reset release
    always @(posedge clk_i) begin
        if (reset_ni) begin
            cycles++;
            if (cycles >= timeout_limit) begin
                $display("timeout after %0d cycles with %0d outputs still pending",
                         cycles, pending);
                tb_errors++;
                print_summary();
                $display("Finished with errors");
                $finish;
            end
        end
    end

    initial begin
        reset_ni      = 1'b0;
        sample        = '0;
        exp_angle     = '0;
        exp_freq      = '0;
        tb_errors     = 0;
        cycles        = 0;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no stimulus lines were read from %s", INPUT_FILE);
            tb_errors++;
        end
        timeout_limit = vectors.size() + `DEMOD_LATENCY + SLACK_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;

        foreach (vectors[n]) begin
            @(negedge clk_i);
            drive_vector(vectors[n]);
        end
        @(negedge clk_i);
        sample = '0;

        // the last result is due DEMOD_LATENCY cycles after its sample
        repeat (`DEMOD_LATENCY + DRAIN_CYCLES) @(negedge clk_i);
        if (pending != 0) begin
            $display("%0d expected results were never produced", pending);
            tb_errors++;
        end

        print_summary();
        if (check_errors + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: fm_demod.f
+incdir+source
source/fm_demod_pkg.sv
source/div.sv
source/atan.sv
source/atan2.sv
source/freq_discriminator.sv
source/fm_demod_top.sv
dv/fm_demod_checker.sv
dv/fm_demod_tb.sv

// File: source/atan.sv
`timescale 1ns/1ns

module atan #(
    parameter int IN_W  = 10,
    parameter int OUT_W = 13
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic [IN_W-1:0]  arg_i,
    output logic [OUT_W-1:0] angle_o
);

    localparam int  DEPTH = 2 ** IN_W;
    localparam real PI    = 3.14159265358979323846;

    logic [OUT_W-1:0] rom [DEPTH];
    logic [IN_W-1:0]  addr_q;

    // entry a holds atan(a / DEPTH) with pi/4 scaled to 2**OUT_W
    initial begin
        real ratio;
        real scaled;
        for (int a = 0; a < DEPTH; a++) begin
            ratio  = real'(a) / real'(DEPTH);
            scaled = $atan(ratio) * (2.0 ** OUT_W) * 4.0 / PI;
            rom[a] = OUT_W'($rtoi(scaled + 0.5));
        end
    end

    // address register, then data register
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            addr_q  <= '0;
            angle_o <= '0;
        end else begin
            addr_q  <= arg_i;
            angle_o <= rom[addr_q];
        end
    end

endmodule

// File: source/atan2.sv
`timescale 1ns/1ns
`include "fm_demod_defs.svh"

module atan2
    import fm_demod_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    output angle_t     angle_o,
    output logic       valid_o
);

    localparam int WIDE_W   = `SAMPLE_W + `RATIO_W;
    localparam int TBL_W    = `ANGLE_W - 3;
    // table address, table data, unfold and output
    localparam int POST_LAT = `ATAN2_LATENCY - `DIV_LATENCY - 1;

    localparam angle_t ANG_PI   = {1'b1, {(`ANGLE_W-1){1'b0}}};
    localparam angle_t ANG_PI_2 = {2'b01, {(`ANGLE_W-2){1'b0}}};
    localparam angle_t ANG_PI_4 = {3'b001, {(`ANGLE_W-3){1'b0}}};
    localparam logic [`SAMPLE_W-1:0] MAG_ONE = 1;

    // equal magnitudes give ratio one which the table cannot hold
    typedef struct packed {
        logic        diag;
        octant_tag_t tag;
    } div_user_t;

    logic [`SAMPLE_W-1:0] abs_x;
    logic [`SAMPLE_W-1:0] abs_y;
    logic [`SAMPLE_W-1:0] small_mag;
    logic [`SAMPLE_W-1:0] large_mag;
    div_user_t            fold_user;

    logic [WIDE_W-1:0]    num_q;
    logic [WIDE_W-1:0]    den_q;
    div_user_t            user_q;
    logic                 fold_valid_q;

    logic [`RATIO_W-1:0]  ratio;
    div_user_t            div_user;
    logic                 div_valid;

    logic [TBL_W-1:0]     tbl_angle;
    div_user_t            tbl_user_q [2];
    logic [POST_LAT-1:0]  post_valid_q;

    angle_t               base_angle;
    angle_t               oct_angle;
    angle_t               full_angle;
    angle_t               unfold_q;

    // fold into the first octant, x is I and y is Q
    always_comb begin
        abs_x = sample_i.i[`SAMPLE_W-1] ? -sample_i.i : sample_i.i;
        abs_y = sample_i.q[`SAMPLE_W-1] ? -sample_i.q : sample_i.q;
        fold_user.tag.swapped  = abs_y > abs_x;
        fold_user.tag.quadrant = quadrant_e'({sample_i.i[`SAMPLE_W-1], sample_i.q[`SAMPLE_W-1]});
        fold_user.diag         = (abs_x == abs_y) && (abs_x != '0);
        small_mag = fold_user.tag.swapped ? abs_x : abs_y;
        large_mag = fold_user.tag.swapped ? abs_y : abs_x;
        // both zero, so 0/1 lands on table entry zero
        if (large_mag == '0) begin
            large_mag = MAG_ONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fold_valid_q <= 1'b0;
        end else begin
            fold_valid_q <= sample_i.valid;
        end
        num_q  <= {small_mag, {`RATIO_W{1'b0}}};
        den_q  <= {{`RATIO_W{1'b0}}, large_mag};
        user_q <= fold_user;
    end

    div #(
        .WIDTH       (WIDE_W),
        .RESULT_WIDTH(`RATIO_W),
        .USER_WIDTH  ($bits(div_user_t))
    ) u_div (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .numerator_i  (num_q),
        .denominator_i(den_q),
        .user_i       (user_q),
        .valid_i      (fold_valid_q),
        .result_o     (ratio),
        .user_o       (div_user),
        .valid_o      (div_valid)
    );

    atan #(
        .IN_W (`RATIO_W),
        .OUT_W(TBL_W)
    ) u_atan (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .arg_i   (ratio),
        .angle_o (tbl_angle)
    );

    // tag and valid follow the two table registers
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            post_valid_q <= '0;
        end else begin
            post_valid_q <= {post_valid_q[POST_LAT-2:0], div_valid};
        end
        tbl_user_q[0] <= div_user;
        tbl_user_q[1] <= tbl_user_q[0];
    end

    // unfold back to the full circle
    always_comb begin
        base_angle = tbl_user_q[1].diag ? ANG_PI_4 : angle_t'(tbl_angle);
        oct_angle  = tbl_user_q[1].tag.swapped ? ANG_PI_2 - base_angle : base_angle;
        case (tbl_user_q[1].tag.quadrant)
            Q1:      full_angle = oct_angle;
            Q2:      full_angle = ANG_PI - oct_angle;
            Q3:      full_angle = oct_angle - ANG_PI;
            default: full_angle = -oct_angle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        unfold_q <= full_angle;
        angle_o  <= unfold_q;
    end

    assign valid_o = post_valid_q[POST_LAT-1];

    // the tag coming back out of the divider is fully known for every valid ratio
    a_tag_known: assert property (@(posedge clk_i) disable iff (!reset_ni)
        div_valid |-> !$isunknown(div_user.tag));

endmodule

// File: source/div.sv
`timescale 1ns/1ns

module div #(
    parameter int WIDTH        = 26,
    parameter int RESULT_WIDTH = 10,
    parameter int USER_WIDTH   = 4
) (
    input  logic                    clk_i,
    input  logic                    reset_ni,
    input  logic [WIDTH-1:0]        numerator_i,
    input  logic [WIDTH-1:0]        denominator_i,
    input  logic [USER_WIDTH-1:0]   user_i,
    input  logic                    valid_i,
    output logic [RESULT_WIDTH-1:0] result_o,
    output logic [USER_WIDTH-1:0]   user_o,
    output logic                    valid_o
);

    // input register plus one stage per quotient bit
    localparam int LATENCY = RESULT_WIDTH + 1;
    // room to shift the divisor up to the top quotient bit
    localparam int EXT_W   = WIDTH + RESULT_WIDTH;

    typedef struct packed {
        logic [WIDTH-1:0]        rem;
        logic [WIDTH-1:0]        den;
        logic [RESULT_WIDTH-1:0] quo;
        logic [USER_WIDTH-1:0]   user;
    } stage_t;

    stage_t             stage_q [LATENCY];
    logic [LATENCY-1:0] valid_q;

    // one restoring step for quotient bit bit_idx
    // a zero divisor passes every trial so the quotient saturates to all ones
    function automatic stage_t div_step(input stage_t s, input int bit_idx);
        logic [EXT_W-1:0] trial;
        stage_t           r;
        trial = EXT_W'(s.den) << bit_idx;
        r     = s;
        if (EXT_W'(s.rem) >= trial) begin
            r.rem          = s.rem - trial[WIDTH-1:0];
            r.quo[bit_idx] = 1'b1;
        end
        return r;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LATENCY-2:0], valid_i};
        end

        stage_q[0].rem  <= numerator_i;
        stage_q[0].den  <= denominator_i;
        stage_q[0].quo  <= '0;
        stage_q[0].user <= user_i;

        // stage k settles bit RESULT_WIDTH-k, msb first
        for (int k = 1; k < LATENCY; k++) begin
            stage_q[k] <= div_step(stage_q[k-1], RESULT_WIDTH - k);
        end
    end

    assign result_o = stage_q[LATENCY-1].quo;
    assign user_o   = stage_q[LATENCY-1].user;
    assign valid_o  = valid_q[LATENCY-1];

    // every accepted division leaves the pipe after exactly LATENCY cycles
    a_latency: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $past(reset_ni, LATENCY) |-> valid_o == $past(valid_i, LATENCY));

endmodule

// File: source/fm_demod_defs.svh
`ifndef FM_DEMOD_DEFS_SVH
`define FM_DEMOD_DEFS_SVH

// width of signed I and Q
`define SAMPLE_W 16

// quotient bits out of the divider, also the arctangent table address
`define RATIO_W 10

// signed binary angle where the full scale stands for one turn
`define ANGLE_W 16

// divider input register plus one stage per quotient bit
`define DIV_LATENCY (`RATIO_W + 1)

// fold, table address, table data, unfold and output registers around the divider
`define ATAN2_LATENCY (`DIV_LATENCY + 5)

// discriminator output register
`define DEMOD_LATENCY (`ATAN2_LATENCY + 1)

`endif

// File: source/fm_demod_pkg.sv
`include "fm_demod_defs.svh"

package fm_demod_pkg;

    // one I/Q pair and its strobe
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] i;
        logic signed [`SAMPLE_W-1:0] q;
        logic                        valid;
    } iq_sample_t;

    // pi is half of full scale so phase wraps in two's complement
    typedef logic signed [`ANGLE_W-1:0] angle_t;

    // code is {i negative, q negative}
    typedef enum logic [1:0] {
        Q1 = 2'b00,
        Q4 = 2'b01,
        Q2 = 2'b10,
        Q3 = 2'b11
    } quadrant_e;

    // travels through the divider next to the ratio
    typedef struct packed {
        logic      swapped;
        quadrant_e quadrant;
    } octant_tag_t;

    // demodulator output word
    typedef struct packed {
        angle_t angle;
        angle_t freq;
        logic   valid;
    } demod_out_t;

endpackage

// File: source/fm_demod_top.sv
`timescale 1ns/1ns

module fm_demod_top
    import fm_demod_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_sample_t sample_i,
    output demod_out_t result_o
);

    // phase of each sample on its way to the discriminator
    angle_t angle;
    logic   angle_valid;

    atan2 u_atan2 (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .sample_i(sample_i),
        .angle_o (angle),
        .valid_o (angle_valid)
    );

    // phase difference of successive samples gives the frequency
    freq_discriminator u_disc (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .angle_i (angle),
        .valid_i (angle_valid),
        .result_o(result_o)
    );

endmodule

// File: source/freq_discriminator.sv
`timescale 1ns/1ns

module freq_discriminator
    import fm_demod_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_ni,
    input  angle_t     angle_i,
    input  logic       valid_i,
    output demod_out_t result_o
);

    // last valid angle
    // starts at zero so the first sample reports its own angle
    angle_t prev_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            prev_q         <= '0;
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid <= valid_i;
            if (valid_i) begin
                prev_q <= angle_i;
            end
        end

        if (valid_i) begin
            result_o.angle <= angle_i;
            // two's complement wrap keeps the step within half a turn
            result_o.freq  <= angle_i - prev_q;
        end
    end

    // nothing may leave the stage right after a reset cycle
    a_idle_after_reset: assert property (@(posedge clk_i)
        !reset_ni |=> !result_o.valid);

endmodule
